// ==== all.f ====
+incdir+verilog
verilog/board_types_pkg.sv
verilog/audio_types_pkg.sv
verilog/i2s_mic_receiver.sv
verilog/meter_config.sv
verilog/level_display.sv
verilog/tm1638_board_controller.sv
verilog/board_top.sv
tb/tb_board_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the board testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_board_top \
    --Mdir obj_dir -o tb_board_top
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_board_top > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    exit 0
fi
exit 1

// ==== tb/tb_board_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "board_params.svh"

module tb_board_top;

    localparam int  N_TESTS      = 24;
    localparam int  CLK_PERIOD   = 20;
    localparam int  FRAME_CLKS   = 64 * 2 * `SCK_DIV;
    localparam int  REFRESH_CLKS = (23 * 17 + 6) * `TM_DIV;  // 23 bytes, 3 gaps
    localparam longint WATCHDOG_NS =
        longint'(N_TESTS) * (4 * FRAME_CLKS + 4 * REFRESH_CLKS) * 2 * CLK_PERIOD;

    logic clk;
    logic arst_n;
    logic mic_sck;
    logic mic_ws;
    logic mic_lr;
    logic mic_sd;
    logic sio_clk;
    logic sio_stb;
    logic sio_data_out;
    logic sio_data_oe;
    logic sio_data_in;

    logic [31:0] rng;
    logic [23:0] cur_sample;
    logic [23:0] mic_word;
    logic [5:0]  mic_per;
    logic [7:0]  key_pattern;
    logic [7:0]  tm_bytes [0:16];
    logic [7:0]  disp_img [0:15];
    logic [7:0]  tm_shift;
    int          tm_nbits;
    int          tm_rbits;
    int          tm_phase;
    int          frame_count;
    int          read_count;
    int          data_count;
    int          errors;

    board_top i_board_top
    (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .mic_sck      ( mic_sck      ),
        .mic_ws       ( mic_ws       ),
        .mic_lr       ( mic_lr       ),
        .mic_sd       ( mic_sd       ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data_out ( sio_data_out ),
        .sio_data_oe  ( sio_data_oe  ),
        .sio_data_in  ( sio_data_in  )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------------------------------------
    // Helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] seg_for_hex(input logic [3:0] n);
        logic [7:0] table_seg [0:15];
        table_seg = '{8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07,
                      8'h7F, 8'h6F, 8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71};
        return table_seg[n];
    endfunction

    function automatic logic [22:0] magnitude(input logic [23:0] v);
        logic [23:0] a;
        a = v[23] ? (~v + 24'd1) : v;
        return a[23] ? 23'h7F_FFFF : a[22:0];  // Most negative value saturates
    endfunction

    function automatic logic led_lit(input logic [22:0] mag, input logic [1:0] gain,
                                     input int i);
        logic [25:0] s;
        s = {3'b000, mag} << gain;
        if (s > 26'h7F_FFFF)
            s = 26'h7F_FFFF;
        return s >= (26'd1 << (15 + i));
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // --------------------------------------------------
    // Microphone model, one bit per falling sck

    always @(negedge mic_sck)
    begin
        #2;
        mic_per = mic_per + 6'd1;
        if (mic_per == 6'd0)
        begin
            mic_word = cur_sample;  // New word at each ws fall
            frame_count++;
            check("mic_lr", mic_lr, 0);
        end
        check("mic_ws", mic_ws, {31'd0, mic_per >= 6'd32});   // Right half is high
        if (mic_per >= 6'd1 && mic_per <= 6'd24)
            mic_sd = mic_word[24 - mic_per];
        else
            mic_sd = 1'b0;
    end

    // --------------------------------------------------
    // TM1638 chip model

    always @(negedge sio_stb)
    begin
        tm_nbits = 0;
        tm_rbits = 0;
    end

    always @(posedge sio_clk)
    begin
        if (sio_stb === 1'b0)
        begin
            if (sio_data_oe)
            begin
                tm_shift = {sio_data_out, tm_shift[7:1]};   // LSB first
                tm_nbits++;
                if (tm_nbits % 8 == 0 && tm_nbits <= 17 * 8)
                    tm_bytes[tm_nbits / 8 - 1] = tm_shift;
            end
            else
                tm_rbits++;
        end
    end

    // Key byte i carries key i in bit0 and key i+4 in bit4
    always @(negedge sio_clk)
    begin
        if (sio_stb === 1'b0 && tm_nbits == 8 && tm_bytes[0] == 8'h42)
        begin
            #2;
            if (tm_rbits % 8 == 0)
                sio_data_in = key_pattern[tm_rbits / 8];
            else if (tm_rbits % 8 == 4)
                sio_data_in = key_pattern[tm_rbits / 8 + 4];
            else
                sio_data_in = 1'b0;
        end
    end

    always @(posedge sio_stb)
    begin
        if (arst_n)
        begin
            case (tm_phase)
                0:
                begin
                    check("sio command", {24'd0, tm_bytes[0]}, 32'h40);
                    check("sio write bits", tm_nbits, 8);
                end
                1:
                begin
                    check("sio command", {24'd0, tm_bytes[0]}, 32'hC0);
                    check("sio write bits", tm_nbits, 17 * 8);
                    for (int i = 0; i < 16; i++)
                        disp_img[i] = tm_bytes[i + 1];
                    data_count++;
                end
                default:
                begin
                    check("sio command", {24'd0, tm_bytes[0]}, 32'h42);
                    check("sio write bits", tm_nbits, 8);   // oe stays low in the read
                    check("sio read bits", tm_rbits, 32);
                    sio_data_in = 1'b1;
                    read_count++;
                end
            endcase
            check("sio idle clock", sio_clk, 1);
            tm_phase = (tm_phase + 1) % 3;
        end
    end

    // --------------------------------------------------
    // Watchdog

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout, the panel or microphone stopped making progress");
        $display("ERRORS FOUND");
        $finish;
    end

    // --------------------------------------------------
    // Main sequence with reference model

    initial
    begin
        logic [23:0] s;
        logic [7:0]  k;
        logic [7:0]  prev_keys;
        logic [7:0]  press;
        logic        mode_peak;
        logic [1:0]  gain;
        logic [22:0] peak;
        logic [23:0] shown;
        logic [22:0] mag;
        int          err0;
        int          f0;
        int          r0;
        int          d0;
        int          failed;

        clk         = 1'b0;
        arst_n      = 1'b0;
        mic_sd      = 1'b0;
        sio_data_in = 1'b1;
        cur_sample  = '0;
        mic_word    = '0;
        mic_per     = '0;
        key_pattern = '0;
        tm_shift    = '0;
        tm_nbits    = 0;
        tm_rbits    = 0;
        tm_phase    = 0;
        frame_count = 0;
        read_count  = 0;
        data_count  = 0;
        errors      = 0;
        failed      = 0;
        rng         = 32'ha86e;
        prev_keys   = '0;
        mode_peak   = 1'b0;
        gain        = 2'd0;
        peak        = '0;

        repeat (10) @(posedge clk);
        #2 arst_n = 1'b1;

        check("sio_stb", sio_stb, 1);
        check("sio_clk", sio_clk, 1);
        check("sio_data_oe", sio_data_oe, 0);
        check("mic_ws", mic_ws, 0);
        check("mic_sck", mic_sck, 0);

        for (int t = 0; t < N_TESTS; t++)
        begin
            err0 = errors;
            rng  = xorshift32(rng);
            s    = rng[23:0];
            rng  = xorshift32(rng);
            k    = (t < 3) ? 8'h00 : rng[7:0];  // First tests stay in hex at gain 0
            if (t == 7)
                s = 24'h80_0000;

            @(posedge clk);
            #2 cur_sample = s;
            if (magnitude(s) > peak)
                peak = magnitude(s);
            f0 = frame_count;
            wait (frame_count >= f0 + 2);

            @(posedge clk);
            #2 key_pattern = k;
            press     = k & ~prev_keys;
            prev_keys = k;
            if (press[0])
                mode_peak = ~mode_peak;
            if (press[1])
                gain = gain + 2'd1;
            if (press[2])
                peak = magnitude(s);    // Only the held sample follows the clear

            r0 = read_count;
            wait (read_count >= r0 + 3);
            d0 = data_count;
            wait (data_count >= d0 + 1);

            mag   = magnitude(s);
            shown = mode_peak ? {1'b0, peak} : s;
            check("digit 0", disp_img[0], seg_for_hex({2'b00, gain}));
            check("digit 1", disp_img[2], mode_peak ? 8'h73 : 8'h00);
            for (int d = 2; d < 8; d++)
                check($sformatf("digit %0d", d), disp_img[2 * d],
                      seg_for_hex(shown[4 * (7 - d) +: 4]));
            for (int i = 0; i < 8; i++)
                check($sformatf("led %0d", i), disp_img[2 * i + 1],
                      {7'd0, led_lit(mag, gain, i)});

            if (errors != err0)
                failed++;
            $display("test %0d sample %h keys %h mode %0d gain %0d : %s", t, s, k,
                     mode_peak, gain, (errors == err0) ? "ok" : "mismatch");
        end

        $display("tests %0d passed %0d failed %0d errors %0d", N_TESTS,
                 N_TESTS - failed, failed, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/board_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module board_top
    import board_types_pkg::*,
           audio_types_pkg::*;
(
    input  logic clk,
    input  logic arst_n,

    output logic mic_sck,
    output logic mic_ws,
    output logic mic_lr,
    input  logic mic_sd,

    output logic sio_clk,
    output logic sio_stb,
    output logic sio_data_out,
    output logic sio_data_oe,
    input  logic sio_data_in
);

    mic_sample_t    sample;
    panel_keys_t    keys;
    meter_cfg_t     cfg;
    logic           peak_clear;
    panel_display_t display;

    // --------------------------------------------------

    i2s_mic_receiver i_mic
    (
        .clk    ( clk     ),
        .arst_n ( arst_n  ),
        .sck    ( mic_sck ),
        .ws     ( mic_ws  ),
        .lr     ( mic_lr  ),
        .sd     ( mic_sd  ),
        .sample ( sample  )
    );

    meter_config i_config
    (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .keys       ( keys       ),
        .cfg        ( cfg        ),
        .peak_clear ( peak_clear )
    );

    level_display i_display
    (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .sample     ( sample     ),
        .cfg        ( cfg        ),
        .peak_clear ( peak_clear ),
        .display    ( display    )
    );

    // Pad buffer for DIO lives outside this top
    tm1638_board_controller i_tm1638
    (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .display      ( display      ),
        .keys         ( keys         ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data_out ( sio_data_out ),
        .sio_data_oe  ( sio_data_oe  ),
        .sio_data_in  ( sio_data_in  )
    );

endmodule

`default_nettype wire

// ==== verilog/tm1638_board_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "board_params.svh"

module tm1638_board_controller
    import board_types_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  panel_display_t display,
    output panel_keys_t    keys,
    output logic           sio_clk,
    output logic           sio_stb,
    output logic           sio_data_out,
    output logic           sio_data_oe,
    input  logic           sio_data_in
);

    typedef enum logic [7:0]
    {
        TM_CMD_WRITE = 8'h40,   // Write, auto increment
        TM_CMD_READ  = 8'h42,   // Key scan
        TM_CMD_ADDR  = 8'hC0    // Start at address 0
    } tm_cmd_e;

    localparam int DIV_W  = $clog2(`TM_DIV + 1);
    localparam int WAIT_W = $clog2(`CLK_MHZ + 1);

    logic [DIV_W - 1:0]  div_cnt;
    logic                half_tick;
    logic [WAIT_W - 1:0] wait_cnt;
    logic                wait_done;
    tm_state_e           state;
    tm_cmd_e             cmd;           // Command being sent or next after GAP
    tm_cmd_e             cmd_after;
    logic [4:0]          half;          // 0 is a lead half, then 8 bits of two halves
    logic [3:0]          byte_cnt;
    logic [7:0]          tx_byte;
    logic [7:0]          rx_byte;
    panel_display_t      snap;
    panel_keys_t         keys_acc;
    panel_keys_t         keys_next;

    assign half_tick = (div_cnt == DIV_W'(`TM_DIV - 1));
    assign wait_done = (wait_cnt == WAIT_W'(`CLK_MHZ - 1));    // About 1 us

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_cnt  <= '0;
            wait_cnt <= '0;
        end
        else
        begin
            div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
            if (state == IDLE && !wait_done)
                wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // --------------------------------------------------
    // Byte mux and key assembly

    always_comb
    begin
        case (state)
            CMD, ADDR: tx_byte = cmd;
            DATA:      tx_byte = byte_cnt[0] ? {7'b0, snap.leds[byte_cnt[3:1]]}
                                             : snap.digits[byte_cnt[3:1]];
            default:   tx_byte = 8'hFF;
        endcase
    end

    always_comb
    begin
        keys_next = keys_acc;
        keys_next[{1'b0, byte_cnt[1:0]}] = rx_byte[0];     // Key i
        keys_next[{1'b1, byte_cnt[1:0]}] = rx_byte[4];     // Key i+4
    end

    assign cmd_after = (cmd == TM_CMD_WRITE) ? TM_CMD_ADDR :
                       (cmd == TM_CMD_ADDR)  ? TM_CMD_READ : TM_CMD_WRITE;

    // --------------------------------------------------
    // Frame sequencer

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state        <= IDLE;
            cmd          <= TM_CMD_WRITE;
            half         <= '0;
            byte_cnt     <= '0;
            keys         <= '0;
            sio_clk      <= 1'b1;
            sio_stb      <= 1'b1;
            sio_data_out <= 1'b1;
            sio_data_oe  <= 1'b0;
        end
        else if (half_tick)
        begin
            case (state)
                IDLE:
                begin
                    if (wait_done)
                        state <= GAP;
                    half <= '0;
                end
                GAP:
                begin
                    half <= (half == 5'd1) ? 5'd0 : half + 1'b1;
                    if (half == 5'd1)
                    begin
                        state       <= (cmd == TM_CMD_ADDR) ? ADDR : CMD;
                        sio_stb     <= 1'b0;
                        sio_data_oe <= 1'b1;
                    end
                end
                default:
                begin
                    if (half != 5'd16)
                    begin
                        half    <= half + 1'b1;
                        sio_clk <= half[0];     // Even half ends into low
                        if (!half[0] && state != READ)
                            sio_data_out <= tx_byte[half[3:1]];
                    end
                    else
                    begin
                        half     <= '0;
                        byte_cnt <= byte_cnt + 1'b1;
                        if (state == CMD && cmd == TM_CMD_READ)
                        begin
                            state        <= READ;
                            byte_cnt     <= '0;
                            sio_data_oe  <= 1'b0;   // Chip drives DIO from here
                            sio_data_out <= 1'b1;
                        end
                        else if (state == ADDR)
                        begin
                            state    <= DATA;
                            byte_cnt <= '0;
                        end
                        else if (state == CMD || (state == DATA && byte_cnt == 4'd15)
                                 || (state == READ && byte_cnt == 4'd3))
                        begin
                            state        <= GAP;
                            cmd          <= cmd_after;
                            sio_stb      <= 1'b1;
                            sio_data_oe  <= 1'b0;
                            sio_data_out <= 1'b1;
                            if (state == READ)
                                keys <= keys_next;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (half_tick && state == GAP && half == 5'd1 && cmd == TM_CMD_ADDR)
            snap <= display;    // One image per data command
        if (half_tick && state == READ && half[0] && half != 5'd16)
            rx_byte[half[3:1]] <= sio_data_in;  // Sampled as sio_clk rises
        if (half_tick && state == READ && half == 5'd16)
            keys_acc <= keys_next;
    end

    // The read command must never fight the chip on DIO
    a_read_released : assert property (@(posedge clk) disable iff (!arst_n)
        (state == READ) |-> !sio_data_oe);

endmodule

`default_nettype wire

// ==== verilog/level_display.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "board_params.svh"

module level_display
    import board_types_pkg::*,
           audio_types_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  mic_sample_t    sample,
    input  meter_cfg_t     cfg,
    input  logic           peak_clear,
    output panel_display_t display
);

    localparam logic [7:0] SEG_P = 8'h73;   // Segments a b e f g

    logic [23:0]    abs_val;
    logic [22:0]    mag;
    logic [22:0]    peak_q;
    logic [22:0]    peak_next;
    logic [23:0]    shown;
    logic [25:0]    shifted;
    logic [22:0]    scaled;
    panel_display_t disp_next;

    function automatic logic [7:0] hex_seg(input logic [3:0] nib);
        case (nib)
            4'h0:    hex_seg = 8'h3F;
            4'h1:    hex_seg = 8'h06;
            4'h2:    hex_seg = 8'h5B;
            4'h3:    hex_seg = 8'h4F;
            4'h4:    hex_seg = 8'h66;
            4'h5:    hex_seg = 8'h6D;
            4'h6:    hex_seg = 8'h7D;
            4'h7:    hex_seg = 8'h07;
            4'h8:    hex_seg = 8'h7F;
            4'h9:    hex_seg = 8'h6F;
            4'hA:    hex_seg = 8'h77;
            4'hB:    hex_seg = 8'h7C;
            4'hC:    hex_seg = 8'h39;
            4'hD:    hex_seg = 8'h5E;
            4'hE:    hex_seg = 8'h79;
            default: hex_seg = 8'h71;
        endcase
    endfunction

    // --------------------------------------------------
    // Magnitude and peak

    assign abs_val = sample.value[23] ? -sample.value : sample.value;
    assign mag     = abs_val[23] ? 23'h7F_FFFF : abs_val[22:0];   // Only -2^23 lands here

    always_comb
    begin
        peak_next = peak_q;
        if (peak_clear)
            peak_next = '0;
        else if (sample.valid && mag > peak_q)
            peak_next = mag;
    end

    // --------------------------------------------------
    // Panel image

    assign shown   = (cfg.mode == MODE_PEAK) ? {1'b0, peak_next} : sample.value;
    assign shifted = {3'b000, mag} << cfg.gain;
    assign scaled  = (|shifted[25:23]) ? 23'h7F_FFFF : shifted[22:0];

    always_comb
    begin
        disp_next.digits[0] = hex_seg({2'b00, cfg.gain});
        disp_next.digits[1] = (cfg.mode == MODE_PEAK) ? SEG_P : 8'h00;
        for (int d = 2; d < `N_DIGITS; d++)
            disp_next.digits[d] = hex_seg(shown[4 * (`N_DIGITS - 1 - d) +: 4]);
        for (int i = 0; i < `N_LEDS; i++)
            disp_next.leds[i] = |(scaled >> (15 + i));  // Top set bit at 15+i or above
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            peak_q  <= '0;
            display <= '0;
        end
        else if (sample.valid || peak_clear)
        begin
            peak_q  <= peak_next;
            display <= disp_next;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/meter_config.sv ====
`timescale 1ns/1ns
`default_nettype none

module meter_config
    import board_types_pkg::*,
           audio_types_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  panel_keys_t keys,
    output meter_cfg_t  cfg,
    output logic        peak_clear
);

    panel_keys_t   keys_q;
    panel_keys_t   press;
    display_mode_e mode;
    logic [1:0]    gain;

    assign press = keys & ~keys_q;  // Rising key levels

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            keys_q     <= '0;
            mode       <= MODE_HEX;
            gain       <= 2'd0;
            peak_clear <= 1'b0;
        end
        else
        begin
            keys_q <= keys;
            if (press[0])
                mode <= (mode == MODE_HEX) ? MODE_PEAK : MODE_HEX;
            if (press[1])
                gain <= gain + 2'd1;    // Wraps after 3
            peak_clear <= press[2];
        end
    end

    assign cfg = '{mode: mode, gain: gain};

    // Key levels come from a slow serial scan, so a clear is never stretched
    a_clear_pulse : assert property (@(posedge clk) disable iff (!arst_n)
        peak_clear |=> !peak_clear);

endmodule

`default_nettype wire

// ==== verilog/i2s_mic_receiver.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "board_params.svh"

module i2s_mic_receiver
    import audio_types_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    output logic        sck,
    output logic        ws,
    output logic        lr,
    input  logic        sd,
    output mic_sample_t sample
);

    localparam int DIV_W = $clog2(`SCK_DIV + 1);

    logic [DIV_W - 1:0] div_cnt;
    logic               div_tick;
    logic               sck_rise;
    logic               sck_fall;
    logic [5:0]         period;     // sck period within the frame
    logic [4:0]         bit_cnt;
    logic               take;
    logic [22:0]        shift_q;
    logic [23:0]        value_q;
    logic               valid_q;

    // --------------------------------------------------
    // sck and ws generation

    assign div_tick = (div_cnt == DIV_W'(`SCK_DIV - 1));
    assign sck_rise = div_tick & ~sck;
    assign sck_fall = div_tick & sck;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            period  <= '0;
        end
        else
        begin
            div_cnt <= div_tick ? '0 : div_cnt + 1'b1;
            if (div_tick)
                sck <= ~sck;
            if (sck_fall)
                period <= period + 1'b1;    // ws follows on falling sck
        end
    end

    assign ws = period[5];  // Low for the left half
    assign lr = 1'b0;       // Mic answers in the left slot

    // --------------------------------------------------
    // Left channel capture

    // MSB sits in period 1, one sck after ws falls
    assign take = sck_rise & (period >= 6'd1) & (period <= 6'd24);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bit_cnt <= '0;
            valid_q <= 1'b0;
        end
        else
        begin
            if (sck_rise && period == 6'd0)
                bit_cnt <= '0;
            else if (take)
                bit_cnt <= bit_cnt + 1'b1;
            valid_q <= take && bit_cnt == 5'd23;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
            shift_q <= {shift_q[21:0], sd};
        if (take && bit_cnt == 5'd23)
            value_q <= {shift_q, sd};   // Holds until the next frame
    end

    assign sample = '{value: value_q, valid: valid_q};

    // Every frame is far longer than one clock
    a_valid_single : assert property (@(posedge clk) disable iff (!arst_n)
        sample.valid |=> !sample.valid);

endmodule

`default_nettype wire

// ==== verilog/audio_types_pkg.sv ====
`default_nettype none

package audio_types_pkg;

    typedef enum logic
    {
        MODE_HEX,   // Raw sample in hex
        MODE_PEAK   // Peak magnitude in hex
    } display_mode_e;

    // One left channel word from the microphone
    typedef struct packed
    {
        logic signed [23:0] value;
        logic               valid;  // Single cycle strobe
    } mic_sample_t;

    typedef struct packed
    {
        display_mode_e mode;
        logic [1:0]    gain;    // LED bar shift, 0 to 3
    } meter_cfg_t;

endpackage

`default_nettype wire

// ==== verilog/board_types_pkg.sv ====
`default_nettype none

`include "board_params.svh"

package board_types_pkg;

    typedef logic [`N_KEYS - 1:0] panel_keys_t;    // Bit k is key k, 1 when pressed

    // Segment byte is {dp, g, f, e, d, c, b, a}, digit 0 is the leftmost
    typedef struct packed
    {
        logic [`N_DIGITS - 1:0][7:0] digits;
        logic [`N_LEDS   - 1:0]      leds;
    } panel_display_t;

    typedef enum logic [2:0]
    {
        IDLE,   // Settle after reset
        CMD,    // Mode command byte, write or read
        ADDR,   // Address command byte
        DATA,   // Display bytes
        READ,   // Key bytes
        GAP     // Strobe high between commands
    } tm_state_e;

endpackage

`default_nettype wire

// ==== verilog/board_params.svh ====
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// System clock
`define CLK_MHZ   48

// Half periods in system clocks
`define SCK_DIV   4     // I2S sck
`define TM_DIV    4     // TM1638 sio_clk

// TM1638 panel
`define N_DIGITS  8
`define N_LEDS    8
`define N_KEYS    8

`endif
